//--- hdl/nfcCommandPkg.sv
`default_nettype none

package nfcCommandPkg;

    // widest way vector any build may select
    localparam int maxWays = 8;

    // host command as latched at acceptance
    typedef struct packed {
        logic [4:0]         option;
        logic [15:0]        length;
        logic [15:0]        colAddress;
        logic [23:0]        rowAddress;
        logic [maxWays-1:0] way;
    } hostCommandT;

    // low two option bits pick the program flavour
    localparam logic [1:0] optionCache      = 2'b01;
    localparam logic [1:0] optionMultiplane = 2'b10;

    // flash opcodes
    localparam logic [7:0] setupOpcode       = 8'h80;
    localparam logic [7:0] confirmPlain      = 8'h10;
    localparam logic [7:0] confirmCache      = 8'h15;
    localparam logic [7:0] confirmMultiplane = 8'h11;

    typedef enum logic [2:0] {
        phaseIdle         = 3'd0,
        phaseCmdLatch     = 3'd1,
        phaseSetupIssue   = 3'd2,
        phaseAddrIssue    = 3'd3,
        phaseDataIssue    = 3'd4,
        phaseConfirmIssue = 3'd5
    } programPhaseT;

    // ones in the lower count bits
    function automatic logic [maxWays-1:0] wayMask(input int count);
        logic [maxWays-1:0] mask;
        mask = '0;
        for (int i = 0; i < maxWays; i++) begin
            if (i < count) begin
                mask[i] = 1'b1;
            end
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

//--- hdl/nfcPrimitivePkg.sv
`default_nettype none

package nfcPrimitivePkg;

    // one bit per primitive, also used for the done vector
    typedef logic [7:0] stepMaskT;

    localparam stepMaskT stepNone           = 8'b0000_0000;
    localparam stepMaskT stepCommandAddress = 8'b0000_1000;
    localparam stepMaskT stepDataOut        = 8'b0000_0100;

    // address phase length as the primitive counts it
    localparam logic [15:0] addressByteCount = 16'd4;

    // command cycle: opcode in the top byte
    typedef struct packed {
        logic [7:0]  opcode;
        logic [31:0] reserved;
    } caCommandT;

    // address cycles, first byte on the bus in the top byte
    typedef struct packed {
        logic [7:0] colLow;
        logic [7:0] colHigh;
        logic [7:0] rowLow;
        logic [7:0] rowMid;
        logic [7:0] rowHigh;
    } caAddressT;

    // CA word, view chosen by caSelect
    typedef union packed {
        caCommandT commandView;
        caAddressT addressView;
    } caWordU;

    typedef struct packed {
        stepMaskT    command;
        logic [7:0]  targetWay;
        logic [15:0] numOfData;
        logic        caSelect;
        caWordU      caData;
    } acgRequestT;

    // nothing issued, command cycle selected
    localparam acgRequestT requestIdle = '{
        command:   stepNone,
        targetWay: 8'h00,
        numOfData: 16'h0000,
        caSelect:  1'b1,
        caData:    40'h00_0000_0000
    };

endpackage

`default_nettype wire

//--- hdl/programCommandLatch.sv
`timescale 1ns/1ps
`default_nettype none

module programCommandLatch
    import nfcCommandPkg::*;
#(
    parameter int         numberOfWays = 4,
    parameter logic [5:0] commandId    = 6'b000011
) (
    input  wire               iSystemClock,
    input  wire               reset,

    input  wire  [5:0]        opcode,
    input  wire               cmdValid,
    input  wire  hostCommandT command,
    output logic              cmdReady,

    // sequencer can take a new command
    input  wire               idle,

    output logic              accept,
    output logic              transValid,
    output hostCommandT       latched
);

    logic opcodeMatch;

    assign opcodeMatch = (opcode == commandId);

    // ready follows the sequencer, other opcodes just wait
    assign cmdReady = idle;
    assign accept   = cmdValid & cmdReady & opcodeMatch;

    // one cycle pulse after the accepting edge
    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            transValid <= 1'b0;
        end else begin
            transValid <= accept;
        end
    end

    // fields are held for the whole command
    always_ff @(posedge iSystemClock) begin
        if (accept) begin
            latched.option     <= command.option;
            latched.length     <= command.length;
            latched.colAddress <= command.colAddress;
            latched.rowAddress <= command.rowAddress;
            // ways above numberOfWays stay clear
            latched.way        <= command.way & wayMask(numberOfWays);
        end
    end

endmodule

`default_nettype wire

//--- hdl/programStepSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module programStepSequencer
    import nfcCommandPkg::*;
    import nfcPrimitivePkg::*;
(
    input  wire          iSystemClock,
    input  wire          reset,

    input  wire          accept,
    input  wire          stepMaskT acgLastStep,

    output logic         idle,
    output programPhaseT nextPhase,
    output logic         lastStep
);

    programPhaseT phase;
    logic         commandAddressDone;
    logic         dataOutDone;

    // done pulses of the two primitives in use
    assign commandAddressDone = |(acgLastStep & stepCommandAddress);
    assign dataOutDone        = |(acgLastStep & stepDataOut);

    always_comb begin
        nextPhase = phase;
        case (phase)
            phaseIdle: begin
                if (accept) begin
                    nextPhase = phaseCmdLatch;
                end
            end
            phaseCmdLatch: begin
                nextPhase = phaseSetupIssue;
            end
            phaseSetupIssue: begin
                if (commandAddressDone) begin
                    nextPhase = phaseAddrIssue;
                end
            end
            phaseAddrIssue: begin
                if (commandAddressDone) begin
                    nextPhase = phaseDataIssue;
                end
            end
            phaseDataIssue: begin
                if (dataOutDone) begin
                    nextPhase = phaseConfirmIssue;
                end
            end
            phaseConfirmIssue: begin
                // the confirm command finishes the page program
                if (commandAddressDone) begin
                    nextPhase = phaseIdle;
                end
            end
            default: begin
                nextPhase = phaseIdle;
            end
        endcase
    end

    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            phase    <= phaseIdle;
            lastStep <= 1'b0;
        end else begin
            phase    <= nextPhase;
            lastStep <= (phase == phaseConfirmIssue) & commandAddressDone;
        end
    end

    // not ready again until the last step pulse is over
    assign idle = (phase == phaseIdle) & ~lastStep;

endmodule

`default_nettype wire

//--- hdl/acgRequestBuilder.sv
`timescale 1ns/1ps
`default_nettype none

module acgRequestBuilder
    import nfcCommandPkg::*;
    import nfcPrimitivePkg::*;
#(
    parameter int numberOfWays = 4
) (
    input  wire          iSystemClock,
    input  wire          reset,

    input  programPhaseT nextPhase,
    input  wire          hostCommandT latched,

    output acgRequestT   acgRequest
);

    acgRequestT requestNext;
    logic [7:0] confirmOpcode;
    logic [7:0] activeWay;

    // confirm flavour from the low option bits
    always_comb begin
        case (latched.option[1:0])
            optionCache:      confirmOpcode = confirmCache;
            optionMultiplane: confirmOpcode = confirmMultiplane;
            default:          confirmOpcode = confirmPlain;
        endcase
    end

    assign activeWay = latched.way & wayMask(numberOfWays);

    always_comb begin
        requestNext           = requestIdle;
        // way is kept between commands
        requestNext.targetWay = acgRequest.targetWay;
        case (nextPhase)
            phaseSetupIssue: begin
                requestNext.command                    = stepCommandAddress;
                requestNext.targetWay                  = activeWay;
                requestNext.caSelect                   = 1'b1;
                requestNext.caData.commandView.opcode   = setupOpcode;
                requestNext.caData.commandView.reserved = '0;
            end
            phaseAddrIssue: begin
                requestNext.command   = stepCommandAddress;
                requestNext.targetWay = activeWay;
                requestNext.numOfData = addressByteCount;
                requestNext.caSelect  = 1'b0;
                // column first, low byte leading
                requestNext.caData.addressView.colLow  = latched.colAddress[7:0];
                requestNext.caData.addressView.colHigh = latched.colAddress[15:8];
                requestNext.caData.addressView.rowLow  = latched.rowAddress[7:0];
                requestNext.caData.addressView.rowMid  = latched.rowAddress[15:8];
                requestNext.caData.addressView.rowHigh = latched.rowAddress[23:16];
            end
            phaseDataIssue: begin
                requestNext.command   = stepDataOut;
                requestNext.targetWay = activeWay;
                requestNext.numOfData = latched.length;
                requestNext.caSelect  = 1'b0;
            end
            phaseConfirmIssue: begin
                requestNext.command                    = stepCommandAddress;
                requestNext.targetWay                  = activeWay;
                requestNext.caSelect                   = 1'b1;
                requestNext.caData.commandView.opcode   = confirmOpcode;
                requestNext.caData.commandView.reserved = '0;
            end
            default: begin
                // idle and latch cycles issue nothing
                requestNext.command = stepNone;
            end
        endcase
    end

    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            acgRequest <= requestIdle;
        end else begin
            acgRequest <= requestNext;
        end
    end

endmodule

`default_nettype wire

//--- hdl/nfcProgramPageTop.sv
`timescale 1ns/1ps
`default_nettype none

module nfcProgramPageTop
    import nfcCommandPkg::*;
    import nfcPrimitivePkg::*;
#(
    parameter int         numberOfWays = 4,
    parameter logic [5:0] commandId    = 6'b000011
) (
    input  wire               iSystemClock,
    input  wire               reset,

    // host command port
    input  wire  [5:0]        opcode,
    input  wire               cmdValid,
    input  wire  hostCommandT command,
    output logic              cmdReady,
    output logic              transValid,
    output logic              lastStep,

    // primitive port
    output acgRequestT        acgRequest,
    input  wire  stepMaskT    acgLastStep
);

    logic         accept;
    logic         sequencerIdle;
    programPhaseT nextPhase;
    hostCommandT  latched;

    programCommandLatch #(
        .numberOfWays (numberOfWays),
        .commandId    (commandId)
    ) commandLatch (
        .iSystemClock (iSystemClock),
        .reset        (reset),
        .opcode       (opcode),
        .cmdValid     (cmdValid),
        .command      (command),
        .cmdReady     (cmdReady),
        .idle         (sequencerIdle),
        .accept       (accept),
        .transValid   (transValid),
        .latched      (latched)
    );

    programStepSequencer stepSequencer (
        .iSystemClock (iSystemClock),
        .reset        (reset),
        .accept       (accept),
        .acgLastStep  (acgLastStep),
        .idle         (sequencerIdle),
        .nextPhase    (nextPhase),
        .lastStep     (lastStep)
    );

    acgRequestBuilder #(
        .numberOfWays (numberOfWays)
    ) requestBuilder (
        .iSystemClock (iSystemClock),
        .reset        (reset),
        .nextPhase    (nextPhase),
        .latched      (latched),
        .acgRequest   (acgRequest)
    );

endmodule

`default_nettype wire

//--- test/tbProgramPageChecks.svh
`ifndef tbProgramPageChecksSvh
`define tbProgramPageChecksSvh

// confirm opcode from the low two option bits
function automatic logic [7:0] confirmFor(input logic [4:0] option);
    if (option[1:0] == 2'b01) begin
        return 8'h15;
    end else if (option[1:0] == 2'b10) begin
        return 8'h11;
    end
    return 8'h10;
endfunction

// only ways that exist in this build survive
function automatic hostCommandT maskWays(input hostCommandT cmd);
    hostCommandT masked;
    masked     = cmd;
    masked.way = cmd.way & wayLimit;
    return masked;
endfunction

// request expected on the primitive port while in a given phase
function automatic acgRequestT expectedRequest(input programPhaseT stage,
                                               input hostCommandT cmd,
                                               input logic [7:0] heldWay);
    acgRequestT req;
    req           = '0;
    req.caSelect  = 1'b1;
    req.targetWay = heldWay;
    case (stage)
        phaseSetupIssue: begin
            req.command = 8'h08;
            req.caData  = {8'h80, 32'h0};
        end
        phaseAddrIssue: begin
            req.command   = 8'h08;
            req.numOfData = 16'd4;
            req.caSelect  = 1'b0;
            // column low byte goes out first
            req.caData    = {cmd.colAddress[7:0], cmd.colAddress[15:8],
                             cmd.rowAddress[7:0], cmd.rowAddress[15:8],
                             cmd.rowAddress[23:16]};
        end
        phaseDataIssue: begin
            req.command   = 8'h04;
            req.numOfData = cmd.length;
            req.caSelect  = 1'b0;
        end
        phaseConfirmIssue: begin
            req.command = 8'h08;
            req.caData  = {confirmFor(cmd.option), 32'h0};
        end
        default: begin
            req.command = 8'h00;
        end
    endcase
    if (req.command != 8'h00) begin
        req.targetWay = cmd.way;
    end
    return req;
endfunction

task automatic stopOnError(input string what);
    $display("** Error at %0t ns: %s", $time, what);
    $display("sim failed");
    $fatal(1, "first mismatch reached");
endtask

task automatic compareRequest(input acgRequestT actual, input acgRequestT expected,
                              input string what);
    if (actual !== expected) begin
        stopOnError($sformatf("%s request is %h, expected %h", what, actual, expected));
    end
endtask

task automatic compareCaWord(input caWordU actual, input caWordU expected,
                             input string what);
    if (actual !== expected) begin
        stopOnError($sformatf("%s CA word is %h, expected %h", what, actual, expected));
    end
endtask

task automatic compareFlag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
        stopOnError($sformatf("%s is %b, expected %b", what, actual, expected));
    end
endtask

task automatic compareCount(input int actual, input int expected, input string what);
    if (actual != expected) begin
        stopOnError($sformatf("%s counted %0d, expected %0d", what, actual, expected));
    end
endtask

`endif

//--- test/tbProgramPage.sv
`timescale 1ns/1ps
`default_nettype none

module tbProgramPage
    import nfcCommandPkg::*;
    import nfcPrimitivePkg::*;
();

    localparam int         numberOfWays     = 4;
    localparam logic [5:0] commandId        = 6'b000011;
    localparam logic [7:0] wayLimit         = 8'((1 << numberOfWays) - 1);
    localparam int         clockPeriod      = 20;
    localparam int         commandCount     = 200;
    localparam int         cyclesPerCommand = 60;

    logic         iSystemClock;
    logic         reset;
    logic [5:0]   opcode;
    logic         cmdValid;
    hostCommandT  command;
    stepMaskT     acgLastStep;
    logic         cmdReady;
    logic         transValid;
    logic         lastStep;
    acgRequestT   acgRequest;

    // reference model state
    programPhaseT modelStage;
    hostCommandT  modelCommand;
    logic         modelBusy;
    logic         modelLast;
    logic         modelTransValid;
    logic [7:0]   heldWay;
    int           transValidCount;
    int           lastStepCount;

    `include "tbProgramPageChecks.svh"

    nfcProgramPageTop #(
        .numberOfWays (numberOfWays),
        .commandId    (commandId)
    ) dut (
        .iSystemClock (iSystemClock),
        .reset        (reset),
        .opcode       (opcode),
        .cmdValid     (cmdValid),
        .command      (command),
        .cmdReady     (cmdReady),
        .transValid   (transValid),
        .lastStep     (lastStep),
        .acgRequest   (acgRequest),
        .acgLastStep  (acgLastStep)
    );

    always #(clockPeriod / 2) iSystemClock = ~iSystemClock;

    function automatic hostCommandT randomCommand();
        hostCommandT cmd;
        logic [31:0] word;
        word           = $urandom();
        cmd.option     = word[4:0];
        cmd.way        = word[15:8];
        word           = $urandom();
        cmd.length     = word[15:0];
        cmd.colAddress = word[31:16];
        word           = $urandom();
        cmd.rowAddress = word[23:0];
        return cmd;
    endfunction

    function automatic logic [5:0] otherOpcode(input logic [5:0] pick);
        return (pick == commandId) ? ~commandId : pick;
    endfunction

    // phase model advanced by the host inputs and the done pulses
    always @(posedge iSystemClock) begin
        if (reset) begin
            modelStage      <= phaseIdle;
            modelBusy       <= 1'b0;
            modelLast       <= 1'b0;
            modelTransValid <= 1'b0;
            heldWay         <= 8'h00;
        end else begin
            modelTransValid <= 1'b0;
            modelLast       <= 1'b0;
            if (modelLast) begin
                modelBusy <= 1'b0;
            end
            case (modelStage)
                phaseIdle: begin
                    if (cmdValid && opcode == commandId && !modelBusy) begin
                        modelStage      <= phaseCmdLatch;
                        modelCommand    <= maskWays(command);
                        modelBusy       <= 1'b1;
                        modelTransValid <= 1'b1;
                    end
                end
                phaseCmdLatch: begin
                    modelStage <= phaseSetupIssue;
                    heldWay    <= modelCommand.way;
                end
                phaseSetupIssue: begin
                    if (acgLastStep[3]) begin
                        modelStage <= phaseAddrIssue;
                    end
                end
                phaseAddrIssue: begin
                    if (acgLastStep[3]) begin
                        modelStage <= phaseDataIssue;
                    end
                end
                phaseDataIssue: begin
                    if (acgLastStep[2]) begin
                        modelStage <= phaseConfirmIssue;
                    end
                end
                phaseConfirmIssue: begin
                    if (acgLastStep[3]) begin
                        modelStage <= phaseIdle;
                        modelLast  <= 1'b1;
                    end
                end
                default: begin
                    modelStage <= phaseIdle;
                end
            endcase
        end
    end

    // outputs are compared mid cycle
    always @(negedge iSystemClock) begin
        acgRequestT expected;
        if (!reset) begin
            expected = expectedRequest(modelStage, modelCommand, heldWay);
            compareFlag(cmdReady, !modelBusy, "cmdReady");
            compareFlag(transValid, modelTransValid, "transValid");
            compareFlag(lastStep, modelLast, "lastStep");
            compareCaWord(acgRequest.caData, expected.caData, "primitive");
            compareRequest(acgRequest, expected, "primitive");
            if (transValid) begin
                transValidCount++;
            end
            if (lastStep) begin
                lastStepCount++;
            end
        end
    end

    // primitive answers each issued step after 1 to 6 cycles
    initial begin
        stepMaskT step;
        int       delay;
        forever begin
            @(negedge iSystemClock);
            if (acgRequest.command != stepNone) begin
                step  = acgRequest.command;
                delay = $urandom_range(1, 6);
                repeat (delay) @(posedge iSystemClock);
                acgLastStep <= step;
                @(posedge iSystemClock);
                acgLastStep <= stepNone;
            end
        end
    end

    initial begin
        #(commandCount * cyclesPerCommand * clockPeriod);
        $display("watchdog: run timed out before all commands completed");
        $display("sim failed");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] word;
        int          gap;
        int          sent;
        void'($urandom(32'h036c_ed8c));
        iSystemClock    = 1'b0;
        reset           = 1'b1;
        opcode          = 6'd0;
        cmdValid        = 1'b0;
        command         = '0;
        acgLastStep     = stepNone;
        transValidCount = 0;
        lastStepCount   = 0;
        sent            = 0;
        repeat (8) @(posedge iSystemClock);
        reset <= 1'b0;

        @(negedge iSystemClock);
        compareFlag(cmdReady, 1'b1, "cmdReady after reset");
        compareFlag(transValid, 1'b0, "transValid after reset");
        compareFlag(lastStep, 1'b0, "lastStep after reset");
        compareFlag(|acgRequest.command, 1'b0, "request command after reset");
        compareFlag(acgRequest.caSelect, 1'b1, "caSelect after reset");

        // a foreign opcode must simply wait
        @(posedge iSystemClock);
        word     = $urandom();
        opcode   <= otherOpcode(word[5:0]);
        cmdValid <= 1'b1;
        command  <= randomCommand();
        repeat (10) begin
            @(negedge iSystemClock);
            compareFlag(cmdReady, 1'b1, "cmdReady under foreign opcode");
            compareFlag(transValid, 1'b0, "transValid under foreign opcode");
            compareFlag(|acgRequest.command, 1'b0, "request under foreign opcode");
        end

        for (int i = 0; i < commandCount; i++) begin
            // zero gap presents the next command straight away
            gap = $urandom_range(0, 3);
            repeat (gap) begin
                @(posedge iSystemClock);
                word     = $urandom();
                opcode   <= otherOpcode(word[5:0]);
                cmdValid <= word[6];
                command  <= randomCommand();
            end
            @(posedge iSystemClock);
            opcode   <= commandId;
            cmdValid <= 1'b1;
            command  <= randomCommand();
            do begin
                @(negedge iSystemClock);
            end while (!transValid);
            sent++;
        end

        @(posedge iSystemClock);
        cmdValid <= 1'b0;
        // the last command is over once the DUT takes commands again
        do begin
            @(negedge iSystemClock);
        end while (!cmdReady);
        repeat (3) @(negedge iSystemClock);
        compareCount(transValidCount, sent, "transValid pulses");
        compareCount(lastStepCount, sent, "lastStep pulses");
        compareFlag(cmdReady, 1'b1, "cmdReady after the last command");
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+test
hdl/nfcCommandPkg.sv
hdl/nfcPrimitivePkg.sv
hdl/programCommandLatch.sv
hdl/programStepSequencer.sv
hdl/acgRequestBuilder.sv
hdl/nfcProgramPageTop.sv
test/tbProgramPage.sv

//--- runSim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f src.f \
    --top-module tbProgramPage \
    -Mdir obj_dir \
    -o simProgramPage

./obj_dir/simProgramPage
